/* Makefile */
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := afe_tb
RTL_TOP    := afe_top
FILELIST   := afe_stream.f
RTL_FILES  := $(shell grep '^hw/' $(FILELIST))
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Some tests failed
PASS_MSG   := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* afe_stream.f */
hw/afe_pkg.sv
hw/afe_cfg_regs.sv
hw/afe_l2_addrgen.sv
hw/afe_sample_router.sv
hw/afe_flag_fsm.sv
hw/afe_top.sv
verif/afe_sva.sv
verif/afe_tb.sv

/* hw/afe_cfg_regs.sv */
// Write-only configuration registers of the AFE readout path, driving channel and flag settings
`timescale 1ns/1ps
`default_nettype none

module afe_cfg_regs (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            cfg_valid_i,
  input  logic [afe_pkg::CfgAwidth-1:0]                   cfg_addr_i,
  input  afe_pkg::afe_data_t                              cfg_wdata_i,
  output afe_pkg::l2_addr_t    [afe_pkg::L2NumChs-1:0]    ch_start_o,
  output afe_pkg::trans_size_t [afe_pkg::L2NumChs-1:0]    ch_size_o,
  output afe_pkg::data_size_t  [afe_pkg::L2NumChs-1:0]    ch_datasize_o,
  output logic                 [afe_pkg::L2NumChs-1:0]    ch_continuous_o,
  output logic                 [afe_pkg::L2NumChs-1:0]    ch_en_pulse_o,
  output logic                 [afe_pkg::L2NumChs-1:0]    ch_clr_pulse_o,
  output afe_pkg::mask_mode_t                             mask_mode_o,
  output logic                                            flag_en_o,
  output afe_pkg::flag_t                                  flag_mask_o,
  output logic                                            flag_clr_o
);

  import afe_pkg::*;

  logic [L2NumChs-1:0] ch_sel;
  logic                mask_mode_wr;
  logic                flag_ctrl_wr;

  // Channel block decode on the upper address bits
  always_comb begin
    for (int i = 0; i < L2NumChs; i++) begin
      ch_sel[i] = cfg_valid_i && ((cfg_addr_i >> 2) == CfgAwidth'(i));
    end
  end

  assign mask_mode_wr = cfg_valid_i && (cfg_addr_i == CfgMaskMode);
  assign flag_ctrl_wr = cfg_valid_i && (cfg_addr_i == CfgFlagCtrl);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ch_start_o      <= '0;
      ch_size_o       <= '0;
      ch_datasize_o   <= '0;
      ch_continuous_o <= '0;
      ch_en_pulse_o   <= '0;
      ch_clr_pulse_o  <= '0;
      mask_mode_o     <= '0;
      flag_en_o       <= 1'b0;
      flag_mask_o     <= '0;
      flag_clr_o      <= 1'b0;
    end else begin
      // Pulses last a single cycle
      ch_en_pulse_o  <= '0;
      ch_clr_pulse_o <= '0;
      flag_clr_o     <= 1'b0;

      for (int i = 0; i < L2NumChs; i++) begin
        if (ch_sel[i]) begin
          case (cfg_addr_i[1:0])
            CfgChStart: ch_start_o[i] <= cfg_wdata_i[L2AwidthNoal-1:0];
            CfgChSize:  ch_size_o[i]  <= cfg_wdata_i[L2TransSize-1:0];
            CfgChCtrl: begin
              ch_datasize_o[i]   <= cfg_wdata_i[1:0];
              ch_continuous_o[i] <= cfg_wdata_i[ChCtrlContBit];
              ch_en_pulse_o[i]   <= cfg_wdata_i[ChCtrlEnBit];
              ch_clr_pulse_o[i]  <= cfg_wdata_i[ChCtrlClrBit];
            end
            default: ;
          endcase
        end
      end

      if (mask_mode_wr) begin
        mask_mode_o <= cfg_wdata_i[1:0];
      end

      if (flag_ctrl_wr) begin
        flag_en_o   <= cfg_wdata_i[FlagCtrlEnBit];
        flag_mask_o <= cfg_wdata_i[FlagCtrlMaskLsb +: AfeFlagWidth];
        flag_clr_o  <= cfg_wdata_i[FlagCtrlClrBit];
      end
    end
  end

endmodule

`default_nettype wire

/* hw/afe_flag_fsm.sv */
// Flag event state machine that raises the flag event and counts flag word transfers
`timescale 1ns/1ps
`default_nettype none

module afe_flag_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flag_tf_i,
  input  logic               flag_clr_i,
  output logic               flag_event_o,
  output afe_pkg::flag_cnt_t flag_cnt_o
);

  import afe_pkg::*;

  flag_state_e state_q;
  flag_state_e state_d;
  flag_cnt_t   cnt_d;
  logic        event_d;

  always_comb begin
    state_d = state_q;
    cnt_d   = flag_cnt_o;
    event_d = 1'b0;

    case (state_q)
      FLAG_IDLE: begin
        if (flag_tf_i) begin
          state_d = FLAG_TRIGGERED;
          cnt_d   = flag_cnt_t'(1);
          event_d = 1'b1;
        end
      end
      FLAG_TRIGGERED: begin
        if (flag_clr_i && !flag_tf_i) begin
          state_d = FLAG_IDLE;
          cnt_d   = '0;
        end else if (flag_clr_i) begin
          // Clear and transfer together restart the count
          cnt_d   = flag_cnt_t'(1);
          event_d = 1'b1;
        end else if (flag_tf_i) begin
          cnt_d = flag_cnt_o + flag_cnt_t'(1);
        end
      end
      default: state_d = FLAG_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FLAG_IDLE;
      flag_cnt_o   <= '0;
      flag_event_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      flag_cnt_o   <= cnt_d;
      flag_event_o <= event_d;
    end
  end

endmodule

`default_nettype wire

/* hw/afe_l2_addrgen.sv */
// Per-channel L2 address generator, instantiated once for every L2 channel in the top level
`timescale 1ns/1ps
`default_nettype none

module afe_l2_addrgen (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  afe_pkg::l2_addr_t    start_i,
  input  afe_pkg::trans_size_t size_i,
  input  afe_pkg::data_size_t  datasize_i,
  input  logic                 continuous_i,
  input  logic                 en_pulse_i,
  input  logic                 clr_pulse_i,
  input  logic                 advance_i,
  output afe_pkg::l2_addr_t    curr_addr_o,
  output afe_pkg::trans_size_t wr_ptr_o,
  output logic                 en_o,
  output logic                 event_o
);

  import afe_pkg::*;

  trans_size_t step;
  trans_size_t bytes_left_q;
  logic        last_beat;

  // Bytes per beat
  assign step      = trans_size_t'(1) << datasize_i;
  assign last_beat = (bytes_left_q <= step);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      curr_addr_o  <= '0;
      wr_ptr_o     <= '0;
      bytes_left_q <= '0;
      en_o         <= 1'b0;
      event_o      <= 1'b0;
    end else begin
      event_o <= 1'b0;

      if (clr_pulse_i) begin
        en_o <= 1'b0;
      end else if (en_pulse_i) begin
        curr_addr_o  <= start_i;
        wr_ptr_o     <= '0;
        bytes_left_q <= size_i;
        en_o         <= 1'b1;
      end else if (advance_i && en_o) begin
        if (last_beat) begin
          // End of transfer
          event_o <= 1'b1;
          if (continuous_i) begin
            curr_addr_o  <= start_i;
            wr_ptr_o     <= '0;
            bytes_left_q <= size_i;
          end else begin
            en_o <= 1'b0;
          end
        end else begin
          curr_addr_o  <= curr_addr_o + l2_addr_t'(step);
          wr_ptr_o     <= wr_ptr_o + step;
          bytes_left_q <= bytes_left_q - step;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/afe_pkg.sv */
// Shared widths, field positions, register map and types, imported by every AFE RTL module
`default_nettype none

package afe_pkg;

  // Sample word layout
  localparam int unsigned AfeDataWidth = 32;
  localparam int unsigned AfePlWidth   = 16;
  localparam int unsigned AfeFlagLsb   = 16;
  localparam int unsigned AfeFlagWidth = 4;
  localparam int unsigned AfeChidLsb   = 28;
  localparam int unsigned AfeChidWidth = 4;

  // L2 side
  localparam int unsigned L2NumChs     = 4;
  localparam int unsigned L2AwidthNoal = 12;
  localparam int unsigned L2TransSize  = 16;

  // Flag path
  localparam int unsigned FlagCntWidth    = 6;
  localparam int unsigned FlagWordChidLsb = 24;

  // Configuration register map, channel i sits at base i*4
  localparam int unsigned           CfgAwidth   = 6;
  localparam logic [1:0]            CfgChStart  = 2'd0;
  localparam logic [1:0]            CfgChSize   = 2'd1;
  localparam logic [1:0]            CfgChCtrl   = 2'd2;
  localparam logic [CfgAwidth-1:0]  CfgMaskMode = 6'h20;
  localparam logic [CfgAwidth-1:0]  CfgFlagCtrl = 6'h21;

  // Bit positions inside the control words
  localparam int unsigned ChCtrlContBit   = 2;
  localparam int unsigned ChCtrlEnBit     = 3;
  localparam int unsigned ChCtrlClrBit    = 4;
  localparam int unsigned FlagCtrlEnBit   = 0;
  localparam int unsigned FlagCtrlMaskLsb = 4;
  localparam int unsigned FlagCtrlClrBit  = 8;

  typedef logic [AfeDataWidth-1:0] afe_data_t;
  typedef logic [L2AwidthNoal-1:0] l2_addr_t;
  typedef logic [L2TransSize-1:0]  trans_size_t;
  typedef logic [AfeChidWidth-1:0] chid_t;
  typedef logic [AfeFlagWidth-1:0] flag_t;
  typedef logic [FlagCntWidth-1:0] flag_cnt_t;
  // Step of 2**code bytes
  typedef logic [1:0]              data_size_t;
  typedef logic [1:0]              mask_mode_t;

  typedef enum logic {
    FLAG_IDLE,
    FLAG_TRIGGERED
  } flag_state_e;

endpackage

`default_nettype wire

/* hw/afe_sample_router.sv */
// Routes buffer samples to the L2 write stage by channel ID and captures flag words
`timescale 1ns/1ps
`default_nettype none

module afe_sample_router (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         buff_valid_i,
  input  afe_pkg::afe_data_t                           buff_rdata_i,
  output logic                                         buff_ready_o,
  input  logic                 [afe_pkg::L2NumChs-1:0] ch_en_i,
  input  afe_pkg::l2_addr_t    [afe_pkg::L2NumChs-1:0] ch_addr_i,
  input  afe_pkg::trans_size_t [afe_pkg::L2NumChs-1:0] ch_wr_ptr_i,
  input  afe_pkg::data_size_t  [afe_pkg::L2NumChs-1:0] ch_datasize_i,
  input  afe_pkg::mask_mode_t                          mask_mode_i,
  input  logic                                         flag_en_i,
  input  afe_pkg::flag_t                               flag_mask_i,
  output logic                 [afe_pkg::L2NumChs-1:0] advance_o,
  output logic                                         l2_valid_o,
  input  logic                                         l2_ready_i,
  output afe_pkg::l2_addr_t                            l2_addr_o,
  output afe_pkg::data_size_t                          l2_size_o,
  output afe_pkg::afe_data_t                           l2_wdata_o,
  output logic                                         flag_valid_o,
  input  logic                                         flag_ready_i,
  output afe_pkg::afe_data_t                           flag_data_o
);

  import afe_pkg::*;

  logic [AfePlWidth-1:0] payload;
  flag_t                 flags;
  chid_t                 chid;
  logic [L2NumChs-1:0]   ch_match;
  l2_addr_t              sel_addr;
  trans_size_t           sel_wr_ptr;
  data_size_t            sel_size;
  afe_data_t             masked_data;
  afe_data_t             flag_word;
  logic                  accept;
  logic                  route;
  logic                  flag_hit;

  assign payload = buff_rdata_i[0 +: AfePlWidth];
  assign flags   = buff_rdata_i[AfeFlagLsb +: AfeFlagWidth];
  assign chid    = buff_rdata_i[AfeChidLsb +: AfeChidWidth];

  // Out-of-range IDs match no channel
  always_comb begin
    ch_match   = '0;
    sel_addr   = '0;
    sel_wr_ptr = '0;
    sel_size   = '0;
    for (int i = 0; i < L2NumChs; i++) begin
      ch_match[i] = ch_en_i[i] && (chid == chid_t'(i));
      if (ch_match[i]) begin
        sel_addr   = ch_addr_i[i];
        sel_wr_ptr = ch_wr_ptr_i[i];
        sel_size   = ch_datasize_i[i];
      end
    end
  end

  always_comb begin
    masked_data = '0;
    case (mask_mode_i)
      2'd0: masked_data = buff_rdata_i;
      2'd1: begin
        masked_data[0 +: AfePlWidth]            = payload;
        masked_data[AfeFlagLsb +: AfeFlagWidth] = flags;
      end
      2'd2: masked_data[0 +: AfePlWidth] = payload;
      default: masked_data = {{(AfeDataWidth-AfePlWidth){payload[AfePlWidth-1]}}, payload};
    endcase
  end

  always_comb begin
    flag_word                                  = '0;
    flag_word[FlagWordChidLsb +: AfeChidWidth] = chid;
    flag_word[AfeFlagLsb +: AfeFlagWidth]      = flags;
    flag_word[0 +: L2TransSize]                = sel_wr_ptr;
  end

  // One beat in flight, so a stalled beat blocks the input
  assign buff_ready_o = !l2_valid_o || l2_ready_i;
  assign accept       = buff_valid_i && buff_ready_o;
  assign route        = accept && (|ch_match);
  assign advance_o    = accept ? ch_match : '0;
  assign flag_hit     = route && flag_en_i && (|(flags & flag_mask_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      l2_valid_o   <= 1'b0;
      flag_valid_o <= 1'b0;
    end else begin
      if (route) begin
        l2_valid_o <= 1'b1;
      end else if (l2_ready_i) begin
        l2_valid_o <= 1'b0;
      end

      // A newer flag replaces a pending one
      if (flag_hit) begin
        flag_valid_o <= 1'b1;
      end else if (flag_ready_i) begin
        flag_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (route) begin
      l2_addr_o  <= sel_addr;
      l2_size_o  <= sel_size;
      l2_wdata_o <= masked_data;
    end
    if (flag_hit) begin
      flag_data_o <= flag_word;
    end
  end

endmodule

`default_nettype wire

/* hw/afe_top.sv */
// Top level of the AFE readout path joining registers, router, flag machine and L2 channels
`timescale 1ns/1ps
`default_nettype none

module afe_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Configuration writes
  input  logic                            cfg_valid_i,
  input  logic [afe_pkg::CfgAwidth-1:0]   cfg_addr_i,
  input  afe_pkg::afe_data_t              cfg_wdata_i,
  // Buffer samples
  input  logic                            buff_valid_i,
  input  afe_pkg::afe_data_t              buff_rdata_i,
  output logic                            buff_ready_o,
  // L2 write
  output logic                            l2_valid_o,
  input  logic                            l2_ready_i,
  output afe_pkg::l2_addr_t               l2_addr_o,
  output afe_pkg::data_size_t             l2_size_o,
  output afe_pkg::afe_data_t              l2_wdata_o,
  // Flag words
  output logic                            flag_valid_o,
  input  logic                            flag_ready_i,
  output afe_pkg::afe_data_t              flag_data_o,
  // Events
  output logic [afe_pkg::L2NumChs-1:0]    l2_event_o,
  output logic                            flag_event_o,
  output afe_pkg::flag_cnt_t              flag_cnt_o
);

  import afe_pkg::*;

  l2_addr_t    [L2NumChs-1:0] ch_start;
  trans_size_t [L2NumChs-1:0] ch_size;
  data_size_t  [L2NumChs-1:0] ch_datasize;
  logic        [L2NumChs-1:0] ch_continuous;
  logic        [L2NumChs-1:0] ch_en_pulse;
  logic        [L2NumChs-1:0] ch_clr_pulse;
  logic        [L2NumChs-1:0] ch_en;
  l2_addr_t    [L2NumChs-1:0] ch_addr;
  trans_size_t [L2NumChs-1:0] ch_wr_ptr;
  logic        [L2NumChs-1:0] advance;
  mask_mode_t                 mask_mode;
  logic                       flag_en;
  flag_t                      flag_mask;
  logic                       flag_clr;
  logic                       flag_tf;

  assign flag_tf = flag_valid_o && flag_ready_i;

  afe_cfg_regs u_cfg_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cfg_valid_i     (cfg_valid_i),
    .cfg_addr_i      (cfg_addr_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .ch_start_o      (ch_start),
    .ch_size_o       (ch_size),
    .ch_datasize_o   (ch_datasize),
    .ch_continuous_o (ch_continuous),
    .ch_en_pulse_o   (ch_en_pulse),
    .ch_clr_pulse_o  (ch_clr_pulse),
    .mask_mode_o     (mask_mode),
    .flag_en_o       (flag_en),
    .flag_mask_o     (flag_mask),
    .flag_clr_o      (flag_clr)
  );

  afe_sample_router u_router (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .buff_valid_i  (buff_valid_i),
    .buff_rdata_i  (buff_rdata_i),
    .buff_ready_o  (buff_ready_o),
    .ch_en_i       (ch_en),
    .ch_addr_i     (ch_addr),
    .ch_wr_ptr_i   (ch_wr_ptr),
    .ch_datasize_i (ch_datasize),
    .mask_mode_i   (mask_mode),
    .flag_en_i     (flag_en),
    .flag_mask_i   (flag_mask),
    .advance_o     (advance),
    .l2_valid_o    (l2_valid_o),
    .l2_ready_i    (l2_ready_i),
    .l2_addr_o     (l2_addr_o),
    .l2_size_o     (l2_size_o),
    .l2_wdata_o    (l2_wdata_o),
    .flag_valid_o  (flag_valid_o),
    .flag_ready_i  (flag_ready_i),
    .flag_data_o   (flag_data_o)
  );

  afe_flag_fsm u_flag_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flag_tf_i    (flag_tf),
    .flag_clr_i   (flag_clr),
    .flag_event_o (flag_event_o),
    .flag_cnt_o   (flag_cnt_o)
  );

  // One address generator per L2 channel
  for (genvar i = 0; i < L2NumChs; i++) begin : gen_l2_ch
    afe_l2_addrgen u_addrgen (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .start_i      (ch_start[i]),
      .size_i       (ch_size[i]),
      .datasize_i   (ch_datasize[i]),
      .continuous_i (ch_continuous[i]),
      .en_pulse_i   (ch_en_pulse[i]),
      .clr_pulse_i  (ch_clr_pulse[i]),
      .advance_i    (advance[i]),
      .curr_addr_o  (ch_addr[i]),
      .wr_ptr_o     (ch_wr_ptr[i]),
      .en_o         (ch_en[i]),
      .event_o      (l2_event_o[i])
    );
  end

endmodule

`default_nettype wire

/* verif/afe_sva.sv */
// Concurrent assertions on the AFE handshakes and event pulses, bound into afe_top
`timescale 1ns/1ps
`default_nettype none

module afe_sva (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         buff_valid_i,
  input logic                         buff_ready_o,
  input logic                         l2_valid_o,
  input logic                         l2_ready_i,
  input afe_pkg::l2_addr_t            l2_addr_o,
  input afe_pkg::data_size_t          l2_size_o,
  input afe_pkg::afe_data_t           l2_wdata_o,
  input logic                         flag_valid_o,
  input logic                         flag_ready_i,
  input afe_pkg::afe_data_t           flag_data_o,
  input logic [afe_pkg::L2NumChs-1:0] l2_event_o,
  input logic                         flag_event_o
);

  // A stalled L2 beat keeps its address, size and data
  l2_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (l2_valid_o && !l2_ready_i) |=>
      (l2_valid_o && $stable(l2_addr_o) && $stable(l2_size_o) && $stable(l2_wdata_o)))
    else $error("L2 write changed while stalled");

  // Only a new capture may replace a pending flag word
  flag_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (flag_valid_o && !flag_ready_i && !(buff_valid_i && buff_ready_o)) |=>
      (flag_valid_o && $stable(flag_data_o)))
    else $error("Flag word changed while stalled");

  flag_event_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flag_event_o |=> !flag_event_o)
    else $error("Flag event high for two cycles");

  l2_event_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|l2_event_o) |=> ((l2_event_o & $past(l2_event_o)) == '0))
    else $error("L2 channel event high for two cycles");

endmodule

bind afe_top afe_sva u_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .buff_valid_i (buff_valid_i),
  .buff_ready_o (buff_ready_o),
  .l2_valid_o   (l2_valid_o),
  .l2_ready_i   (l2_ready_i),
  .l2_addr_o    (l2_addr_o),
  .l2_size_o    (l2_size_o),
  .l2_wdata_o   (l2_wdata_o),
  .flag_valid_o (flag_valid_o),
  .flag_ready_i (flag_ready_i),
  .flag_data_o  (flag_data_o),
  .l2_event_o   (l2_event_o),
  .flag_event_o (flag_event_o)
);

`default_nettype wire

/* verif/afe_tb.sv */
// Random-stimulus testbench for the AFE readout path, checks afe_top against a cycle model
`timescale 1ns/1ps
`default_nettype none

module afe_tb;

  import afe_pkg::*;

  localparam int NumRounds       = 8;
  localparam int SamplesPerRound = 48;
  localparam int CfgCycles       = 40;
  localparam int TimeoutCycles   = 4 * NumRounds * SamplesPerRound + NumRounds * CfgCycles;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 cfg_valid_i;
  logic [CfgAwidth-1:0] cfg_addr_i;
  afe_data_t            cfg_wdata_i;
  logic                 buff_valid_i;
  afe_data_t            buff_rdata_i;
  logic                 buff_ready_o;
  logic                 l2_valid_o;
  logic                 l2_ready_i;
  l2_addr_t             l2_addr_o;
  data_size_t           l2_size_o;
  afe_data_t            l2_wdata_o;
  logic                 flag_valid_o;
  logic                 flag_ready_i;
  afe_data_t            flag_data_o;
  logic [L2NumChs-1:0]  l2_event_o;
  logic                 flag_event_o;
  flag_cnt_t            flag_cnt_o;

  // Model of the configuration registers and the pulses they emit
  l2_addr_t            m_start    [L2NumChs];
  trans_size_t         m_size     [L2NumChs];
  data_size_t          m_dsize    [L2NumChs];
  logic                m_cont     [L2NumChs];
  logic                m_en_pend  [L2NumChs];
  logic                m_clr_pend [L2NumChs];
  mask_mode_t          m_mask_mode;
  logic                m_flag_en;
  flag_t               m_flag_mask;
  logic                m_flag_clr_pend;
  // Model of the channel counters
  l2_addr_t            m_addr [L2NumChs];
  trans_size_t         m_ptr  [L2NumChs];
  trans_size_t         m_left [L2NumChs];
  logic                m_en   [L2NumChs];
  logic [L2NumChs-1:0] m_l2_ev;
  // Model of the flag path
  logic                m_flag_valid;
  afe_data_t           m_flag_word;
  logic                m_fsm_trig;
  flag_cnt_t           m_cnt;
  logic                m_flag_ev;

  // Expected L2 beats as {addr, size, data}
  logic [45:0]         beat_q [$];
  int                  n_beats_exp  = 0;
  int                  n_beats_seen = 0;
  int                  n_fev_exp    = 0;
  int                  n_fev_seen   = 0;
  int                  cycle_cnt    = 0;
  integer              seed;
  integer              ready_seed;
  logic [31:0]         ready_rnd;

  afe_top UUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_valid_i  (cfg_valid_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .buff_valid_i (buff_valid_i),
    .buff_rdata_i (buff_rdata_i),
    .buff_ready_o (buff_ready_o),
    .l2_valid_o   (l2_valid_o),
    .l2_ready_i   (l2_ready_i),
    .l2_addr_o    (l2_addr_o),
    .l2_size_o    (l2_size_o),
    .l2_wdata_o   (l2_wdata_o),
    .flag_valid_o (flag_valid_o),
    .flag_ready_i (flag_ready_i),
    .flag_data_o  (flag_data_o),
    .l2_event_o   (l2_event_o),
    .flag_event_o (flag_event_o),
    .flag_cnt_o   (flag_cnt_o)
  );

  always #2 clk_i = ~clk_i;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  function automatic afe_data_t expected_data(input mask_mode_t mode, input afe_data_t s);
    logic [15:0] pl;
    pl = s[15:0];
    case (mode)
      2'd0:    expected_data = s;
      2'd1:    expected_data = {12'h000, s[19:16], pl};
      2'd2:    expected_data = {16'h0000, pl};
      default: expected_data = {{16{pl[15]}}, pl};
    endcase
  endfunction

  task automatic model_reset();
    for (int c = 0; c < L2NumChs; c++) begin
      m_start[c]    = '0;
      m_size[c]     = '0;
      m_dsize[c]    = '0;
      m_cont[c]     = 1'b0;
      m_en_pend[c]  = 1'b0;
      m_clr_pend[c] = 1'b0;
      m_addr[c]     = '0;
      m_ptr[c]      = '0;
      m_left[c]     = '0;
      m_en[c]       = 1'b0;
    end
    m_l2_ev         = '0;
    m_mask_mode     = '0;
    m_flag_en       = 1'b0;
    m_flag_mask     = '0;
    m_flag_clr_pend = 1'b0;
    m_flag_valid    = 1'b0;
    m_flag_word     = '0;
    m_fsm_trig      = 1'b0;
    m_cnt           = '0;
    m_flag_ev       = 1'b0;
  endtask

  // Called at the falling edge, predicts the state after the next rising edge
  task automatic model_step();
    logic [45:0]          beat;
    logic                 tf;
    logic                 accept;
    logic                 routed;
    chid_t                chid;
    flag_t                flags;
    trans_size_t          step;
    int                   ch;
    int                   wr_ch;
    logic [CfgAwidth-1:0] a;

    compare_value("l2_valid_o", 32'(l2_valid_o), 32'(beat_q.size() != 0));
    compare_value("buff_ready_o", 32'(buff_ready_o), 32'(beat_q.size() == 0 || l2_ready_i));
    compare_value("flag_valid_o", 32'(flag_valid_o), 32'(m_flag_valid));
    compare_value("flag_cnt_o", 32'(flag_cnt_o), 32'(m_cnt));
    compare_value("flag_event_o", 32'(flag_event_o), 32'(m_flag_ev));
    compare_value("l2_event_o", 32'(l2_event_o), 32'(m_l2_ev));
    if (flag_event_o) begin
      n_fev_seen++;
    end

    if (l2_valid_o && l2_ready_i) begin
      beat = beat_q.pop_front();
      compare_value("l2_addr_o", 32'(l2_addr_o), 32'(beat[45:34]));
      compare_value("l2_size_o", 32'(l2_size_o), 32'(beat[33:32]));
      compare_value("l2_wdata_o", l2_wdata_o, beat[31:0]);
      n_beats_seen++;
    end

    tf = m_flag_valid && flag_ready_i;
    if (tf) begin
      compare_value("flag_data_o", flag_data_o, m_flag_word);
    end

    // Flag event machine
    m_flag_ev = 1'b0;
    if (!m_fsm_trig) begin
      if (tf) begin
        m_fsm_trig = 1'b1;
        m_cnt      = flag_cnt_t'(1);
        m_flag_ev  = 1'b1;
      end
    end else if (m_flag_clr_pend && !tf) begin
      m_fsm_trig = 1'b0;
      m_cnt      = '0;
    end else if (m_flag_clr_pend) begin
      m_cnt     = flag_cnt_t'(1);
      m_flag_ev = 1'b1;
    end else if (tf) begin
      m_cnt = m_cnt + flag_cnt_t'(1);
    end
    if (m_flag_ev) begin
      n_fev_exp++;
    end

    // Sample routing
    accept = buff_valid_i && buff_ready_o;
    chid   = buff_rdata_i[31:28];
    flags  = buff_rdata_i[19:16];
    ch     = int'(chid);
    routed = 1'b0;
    if (accept && ch < L2NumChs) begin
      routed = m_en[ch];
    end
    if (tf) begin
      m_flag_valid = 1'b0;
    end
    if (routed) begin
      beat_q.push_back({m_addr[ch], m_dsize[ch], expected_data(m_mask_mode, buff_rdata_i)});
      n_beats_exp++;
      if (m_flag_en && (flags & m_flag_mask) != 4'h0) begin
        m_flag_valid = 1'b1;
        m_flag_word  = {4'h0, chid, 4'h0, flags, m_ptr[ch]};
      end
    end

    // Channel counters, clear beats enable beats advance
    for (int c = 0; c < L2NumChs; c++) begin
      step       = trans_size_t'(1) << m_dsize[c];
      m_l2_ev[c] = 1'b0;
      if (m_clr_pend[c]) begin
        m_en[c] = 1'b0;
      end else if (m_en_pend[c]) begin
        m_addr[c] = m_start[c];
        m_ptr[c]  = '0;
        m_left[c] = m_size[c];
        m_en[c]   = 1'b1;
      end else if (routed && ch == c) begin
        if (m_left[c] <= step) begin
          m_l2_ev[c] = 1'b1;
          if (m_cont[c]) begin
            m_addr[c] = m_start[c];
            m_ptr[c]  = '0;
            m_left[c] = m_size[c];
          end else begin
            m_en[c] = 1'b0;
          end
        end else begin
          m_addr[c] = m_addr[c] + l2_addr_t'(step);
          m_ptr[c]  = m_ptr[c] + step;
          m_left[c] = m_left[c] - step;
        end
      end
      m_en_pend[c]  = 1'b0;
      m_clr_pend[c] = 1'b0;
    end

    // Register writes take effect after this edge
    m_flag_clr_pend = 1'b0;
    if (cfg_valid_i) begin
      a = cfg_addr_i;
      if (a == CfgMaskMode) begin
        m_mask_mode = cfg_wdata_i[1:0];
      end else if (a == CfgFlagCtrl) begin
        m_flag_en       = cfg_wdata_i[0];
        m_flag_mask     = cfg_wdata_i[7:4];
        m_flag_clr_pend = cfg_wdata_i[8];
      end else if (a[5:4] == 2'b00) begin
        wr_ch = int'(a[3:2]);
        case (a[1:0])
          2'd0: m_start[wr_ch] = cfg_wdata_i[11:0];
          2'd1: m_size[wr_ch] = cfg_wdata_i[15:0];
          2'd2: begin
            m_dsize[wr_ch]    = cfg_wdata_i[1:0];
            m_cont[wr_ch]     = cfg_wdata_i[2];
            m_en_pend[wr_ch]  = cfg_wdata_i[3];
            m_clr_pend[wr_ch] = cfg_wdata_i[4];
          end
          default: ;
        endcase
      end
    end
  endtask

  task automatic cfg_write(input logic [CfgAwidth-1:0] addr, input afe_data_t data);
    cfg_valid_i = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #1;
    cfg_valid_i = 1'b0;
  endtask

  task automatic configure_round(input int r);
    afe_data_t  rnd;
    afe_data_t  ctrl;
    logic [3:0] fmask;
    logic       fen;
    logic       fclr;
    cfg_write(CfgMaskMode, afe_data_t'(r % 4));
    rnd   = $random(seed);
    // Early rounds keep every flag enabled so the counter wraps
    fen   = (r < 4) ? 1'b1 : rnd[0];
    fmask = (r < 4) ? 4'hf : rnd[7:4];
    fclr  = (r == 4 || r == 6);
    cfg_write(CfgFlagCtrl, {23'h0, fclr, fmask, 3'h0, fen});
    for (int c = 0; c < L2NumChs; c++) begin
      rnd = $random(seed);
      cfg_write(CfgAwidth'(4 * c), {20'h0, rnd[11:0]});
      rnd = $random(seed);
      // Longer than the widest step so end events stay at least two beats apart
      cfg_write(CfgAwidth'(4 * c + 1), afe_data_t'(9 + int'(rnd[4:0])));
      rnd = $random(seed);
      if (rnd[7:6] != 2'b00) begin
        ctrl = {27'h0, 1'b0, 1'b1, rnd[2], rnd[1:0]};
      end else begin
        ctrl = {27'h0, 1'b1, 1'b0, rnd[2], rnd[1:0]};
      end
      cfg_write(CfgAwidth'(4 * c + 2), ctrl);
    end
  endtask

  // Channel IDs 4 and 5 select no channel
  task automatic send_sample();
    afe_data_t d;
    int        sel;
    d            = $random(seed);
    sel          = ($random(seed) & 32'h7fff_ffff) % 6;
    d[31:28]     = 4'(sel);
    buff_valid_i = 1'b1;
    buff_rdata_i = d;
    @(negedge clk_i);
    while (!buff_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    buff_valid_i = 1'b0;
    if (d[20]) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic drain_outputs();
    while (l2_valid_o || flag_valid_o) begin
      @(posedge clk_i);
      #1;
    end
    repeat (2) @(posedge clk_i);
    #1;
  endtask

  always @(negedge clk_i) begin
    if (rst_ni) begin
      model_step();
    end
  end

  // Random back-pressure on both output ports
  always @(posedge clk_i) begin
    #1;
    ready_rnd    = $random(ready_seed);
    l2_ready_i   = (ready_rnd[1:0] != 2'b00);
    flag_ready_i = (ready_rnd[3:2] != 2'b00);
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Some tests failed");
      $fatal(1);
    end
  end

  initial begin
    seed         = 32'hb99b;
    ready_seed   = 32'hb99b ^ 32'h0000_ffff;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    cfg_valid_i  = 1'b0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    buff_valid_i = 1'b0;
    buff_rdata_i = '0;
    l2_ready_i   = 1'b0;
    flag_ready_i = 1'b0;
    model_reset();
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int r = 0; r < NumRounds; r++) begin
      configure_round(r);
      repeat (SamplesPerRound) send_sample();
      drain_outputs();
    end

    $display("Checked %0d L2 beats and %0d flag events", n_beats_seen, n_fev_seen);
    if (n_beats_seen == n_beats_exp && n_fev_seen == n_fev_exp && beat_q.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("[ERROR] %0t l2 beats %0d expected %0d, flag events %0d expected %0d",
               $time, n_beats_seen, n_beats_exp, n_fev_seen, n_fev_exp);
      $display("Some tests failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
